// ==== rv_macros.svh ====
////////////////////////////////////////////////////////////
// RV32I core constants
// Data width, register file geometry and reset vector
////////////////////////////////////////////////////////////
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Data and address width
`define RV_XLEN 32

// Integer register file
`define RV_NUM_REGS 32
`define RV_REG_AW 5

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== rv_isa_pkg.sv ====
////////////////////////////////////////////////////////////
// RV32I instruction set types
// Opcodes, funct3 codes and the raw instruction layout
////////////////////////////////////////////////////////////
`default_nettype none
`include "rv_macros.svh"

package rv_isa_pkg;

  typedef logic [`RV_XLEN-1:0]   xlen_t;
  typedef logic [`RV_REG_AW-1:0] reg_idx_t;

  // Base opcode map, low two bits always 2'b11
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b00_000_11,
    OPC_STORE    = 7'b01_000_11,
    OPC_BRANCH   = 7'b11_000_11,
    OPC_JALR     = 7'b11_001_11,
    OPC_MISC_MEM = 7'b00_011_11,  // FENCE
    OPC_JAL      = 7'b11_011_11,
    OPC_OP_IMM   = 7'b00_100_11,
    OPC_OP       = 7'b01_100_11,
    OPC_SYSTEM   = 7'b11_100_11,
    OPC_AUIPC    = 7'b00_101_11,
    OPC_LUI      = 7'b01_101_11
  } opcode_e;

  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_f3_e;

  // Shared by OP and OP_IMM, funct7 picks SUB and SRA
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } alu_f3_e;

  // R-type view, other formats are sliced out in decode
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_e    opcode;
  } insn_t;

endpackage

`default_nettype wire

// ==== rv_core_pkg.sv ====
////////////////////////////////////////////////////////////
// RV32I micro-architecture types
// ALU ops, decoded control word, data memory request
////////////////////////////////////////////////////////////
`default_nettype none

package rv_core_pkg;

  import rv_isa_pkg::*;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // LUI
  } alu_op_e;

  // All-zero value is a no-op
  typedef struct packed {
    alu_op_e    alu_op;
    logic       use_imm;      // Operand B is imm
    logic       use_pc;       // Operand A is PC
    xlen_t      imm;
    reg_idx_t   rd;
    logic       reg_we;
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    branch_f3_e branch_cond;
    logic       is_jal;
    logic       is_jalr;
    logic       is_ecall;
  } ctrl_t;

  typedef struct packed {
    xlen_t addr;
    xlen_t wdata;
    logic  we;
  } dmem_req_t;

endpackage

`default_nettype wire

// ==== rv_fetch.sv ====
////////////////////////////////////////////////////////////
// RV32I fetch stage
// PC register, next-PC select and sticky halt flag
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "rv_macros.svh"

module rv_fetch (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               i_branch_taken,
  input  wire rv_isa_pkg::xlen_t  i_target,
  input  wire logic               i_ecall,
  output rv_isa_pkg::xlen_t       o_pc,
  output logic                    o_halt
);
  import rv_isa_pkg::*;

  xlen_t pc_q;
  xlen_t pc_next;
  logic  halt_q;

  assign pc_next = i_branch_taken ? i_target : pc_q + xlen_t'(4);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q   <= `RV_RESET_PC;
      halt_q <= 1'b0;
    end else if (!halt_q) begin
      if (i_ecall) begin
        halt_q <= 1'b1;  // PC stays on the ECALL
      end else begin
        pc_q <= pc_next;
      end
    end
  end

  assign o_pc   = pc_q;
  assign o_halt = halt_q;

  // Jump and branch targets from execute must keep the PC on a word
  assert property (@(posedge clk) disable iff (rst) pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== rv_decode.sv ====
////////////////////////////////////////////////////////////
// RV32I decode stage
// Immediate generation and control word decode
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module rv_decode (
  input  wire rv_isa_pkg::insn_t  i_insn,
  output rv_core_pkg::ctrl_t      o_ctrl,
  output rv_isa_pkg::reg_idx_t    o_rs1,
  output rv_isa_pkg::reg_idx_t    o_rs2
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  logic [31:0] raw;
  xlen_t       imm_i, imm_s, imm_b, imm_j, imm_u;
  alu_f3_e     f3;
  logic        f7_zero, f7_alt;

  function automatic alu_op_e f3_to_alu(input alu_f3_e f, input logic alt);
    case (f)
      F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SR:   return alt ? ALU_SRA : ALU_SRL;
      F3_OR:   return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign raw     = i_insn;
  assign f3      = alu_f3_e'(i_insn.funct3);
  assign f7_zero = i_insn.funct7 == 7'h00;
  assign f7_alt  = i_insn.funct7 == 7'h20;  // SUB / SRA

  // Sign-extended immediates per format
  assign imm_i = {{20{raw[31]}}, raw[31:20]};
  assign imm_s = {{20{raw[31]}}, raw[31:25], raw[11:7]};
  assign imm_b = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
  assign imm_j = {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};
  assign imm_u = {raw[31:12], 12'h000};

  assign o_rs1 = i_insn.rs1;
  assign o_rs2 = i_insn.rs2;

  always_comb begin
    o_ctrl    = '0;
    o_ctrl.rd = i_insn.rd;
    case (i_insn.opcode)
      OPC_LUI: begin
        o_ctrl.imm     = imm_u;
        o_ctrl.use_imm = 1'b1;
        o_ctrl.alu_op  = ALU_PASS_B;
        o_ctrl.reg_we  = 1'b1;
      end
      OPC_AUIPC: begin
        o_ctrl.imm     = imm_u;
        o_ctrl.use_imm = 1'b1;
        o_ctrl.use_pc  = 1'b1;
        o_ctrl.reg_we  = 1'b1;
      end
      OPC_JAL: begin
        o_ctrl.imm    = imm_j;
        o_ctrl.is_jal = 1'b1;
        o_ctrl.reg_we = 1'b1;
      end
      OPC_JALR: begin
        o_ctrl.imm     = imm_i;
        o_ctrl.is_jalr = i_insn.funct3 == 3'b000;
        o_ctrl.reg_we  = i_insn.funct3 == 3'b000;
      end
      OPC_BRANCH: begin
        o_ctrl.imm         = imm_b;
        o_ctrl.branch_cond = branch_f3_e'(i_insn.funct3);
        o_ctrl.is_branch   = i_insn.funct3[2:1] != 2'b01;  // 010/011 reserved
      end
      OPC_LOAD: begin
        o_ctrl.imm     = imm_i;
        o_ctrl.use_imm = 1'b1;
        o_ctrl.is_load = i_insn.funct3 == 3'b010;  // LW only
        o_ctrl.reg_we  = i_insn.funct3 == 3'b010;
      end
      OPC_STORE: begin
        o_ctrl.imm      = imm_s;
        o_ctrl.use_imm  = 1'b1;
        o_ctrl.is_store = i_insn.funct3 == 3'b010;  // SW only
      end
      OPC_OP_IMM: begin
        o_ctrl.imm     = imm_i;
        o_ctrl.use_imm = 1'b1;
        o_ctrl.alu_op  = f3_to_alu(f3, (f3 == F3_SR) && f7_alt);
        case (f3)
          F3_SLL:  o_ctrl.reg_we = f7_zero;
          F3_SR:   o_ctrl.reg_we = f7_zero || f7_alt;
          default: o_ctrl.reg_we = 1'b1;
        endcase
      end
      OPC_OP: begin
        o_ctrl.alu_op = f3_to_alu(f3, f7_alt);
        o_ctrl.reg_we = f7_zero || (f7_alt && (f3 == F3_ADD || f3 == F3_SR));
      end
      OPC_SYSTEM: o_ctrl.is_ecall = raw[31:7] == 25'd0;
      default: ;  // FENCE and unknown opcodes fall through as no-ops
    endcase
  end

endmodule

`default_nettype wire

// ==== rv_regfile.sv ====
////////////////////////////////////////////////////////////
// RV32I integer register file
// Two combinational read ports, one write port, x0 fixed
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "rv_macros.svh"

module rv_regfile (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire rv_isa_pkg::reg_idx_t  i_rs1,
  input  wire rv_isa_pkg::reg_idx_t  i_rs2,
  output rv_isa_pkg::xlen_t          o_rs1_data,
  output rv_isa_pkg::xlen_t          o_rs2_data,
  input  wire rv_isa_pkg::reg_idx_t  i_rd,
  input  wire rv_isa_pkg::xlen_t     i_rd_data,
  input  wire logic                  i_we
);
  import rv_isa_pkg::*;

  xlen_t regs [`RV_NUM_REGS];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int idx = 0; idx < `RV_NUM_REGS; idx++) begin
        regs[idx] <= '0;
      end
    end else if (i_we && i_rd != '0) begin
      regs[i_rd] <= i_rd_data;  // x0 never written
    end
  end

  // x0 reads zero
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// ==== rv_execute.sv ====
////////////////////////////////////////////////////////////
// RV32I execute stage
// ALU, branch compare and jump/branch target generation
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module rv_execute (
  input  wire rv_isa_pkg::xlen_t   i_pc,
  input  wire rv_core_pkg::ctrl_t  i_ctrl,
  input  wire rv_isa_pkg::xlen_t   i_rs1_data,
  input  wire rv_isa_pkg::xlen_t   i_rs2_data,
  output rv_isa_pkg::xlen_t        o_result,
  output logic                     o_branch_taken,
  output rv_isa_pkg::xlen_t        o_target
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  xlen_t      op_a, op_b;
  xlen_t      jalr_sum;
  logic [4:0] shamt;
  logic       cond_met;

  assign op_a  = i_ctrl.use_pc  ? i_pc       : i_rs1_data;
  assign op_b  = i_ctrl.use_imm ? i_ctrl.imm : i_rs2_data;
  assign shamt = op_b[4:0];

  // Also the effective address for LW/SW
  always_comb begin
    case (i_ctrl.alu_op)
      ALU_ADD:    o_result = op_a + op_b;
      ALU_SUB:    o_result = op_a - op_b;
      ALU_SLL:    o_result = op_a << shamt;
      ALU_SLT:    o_result = xlen_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU:   o_result = xlen_t'(op_a < op_b);
      ALU_XOR:    o_result = op_a ^ op_b;
      ALU_SRL:    o_result = op_a >> shamt;
      ALU_SRA:    o_result = xlen_t'($signed(op_a) >>> shamt);
      ALU_OR:     o_result = op_a | op_b;
      ALU_AND:    o_result = op_a & op_b;
      ALU_PASS_B: o_result = op_b;
      default:    o_result = '0;
    endcase
  end

  always_comb begin
    case (i_ctrl.branch_cond)
      BR_BEQ:  cond_met = i_rs1_data == i_rs2_data;
      BR_BNE:  cond_met = i_rs1_data != i_rs2_data;
      BR_BLT:  cond_met = $signed(i_rs1_data) < $signed(i_rs2_data);
      BR_BGE:  cond_met = $signed(i_rs1_data) >= $signed(i_rs2_data);
      BR_BLTU: cond_met = i_rs1_data < i_rs2_data;
      BR_BGEU: cond_met = i_rs1_data >= i_rs2_data;
      default: cond_met = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1_data + i_ctrl.imm;

  // JALR clears bit 0, everything else is PC relative
  assign o_target = i_ctrl.is_jalr ? (jalr_sum & ~xlen_t'(1)) : i_pc + i_ctrl.imm;

  assign o_branch_taken = i_ctrl.is_jal || i_ctrl.is_jalr || (i_ctrl.is_branch && cond_met);

endmodule

`default_nettype wire

// ==== rv_mem_wb.sv ====
////////////////////////////////////////////////////////////
// RV32I memory and writeback stage
// Store request, load return and rd value select
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module rv_mem_wb (
  input  wire logic                rst,
  input  wire rv_isa_pkg::xlen_t   i_pc,
  input  wire rv_core_pkg::ctrl_t  i_ctrl,
  input  wire rv_isa_pkg::xlen_t   i_result,
  input  wire rv_isa_pkg::xlen_t   i_rs2_data,
  input  wire logic                i_halt,
  input  wire rv_isa_pkg::xlen_t   i_dmem_rdata,
  output rv_core_pkg::dmem_req_t   o_dmem,
  output rv_isa_pkg::xlen_t        o_rd_data,
  output logic                     o_rd_we
);
  import rv_isa_pkg::*;

  xlen_t link_addr;
  logic  aligned;
  logic  live;  // Core is running

  assign link_addr = i_pc + xlen_t'(4);
  assign aligned   = i_result[1:0] == 2'b00;
  assign live      = !rst && !i_halt;

  assign o_dmem.addr  = i_result;
  assign o_dmem.wdata = i_rs2_data;
  assign o_dmem.we    = live && i_ctrl.is_store && aligned;

  // Misaligned LW leaves rd untouched
  assign o_rd_we = live && i_ctrl.reg_we && (!i_ctrl.is_load || aligned);

  always_comb begin
    if (i_ctrl.is_load) begin
      o_rd_data = i_dmem_rdata;
    end else if (i_ctrl.is_jal || i_ctrl.is_jalr) begin
      o_rd_data = link_addr;  // Return address
    end else begin
      o_rd_data = i_result;
    end
  end

endmodule

`default_nettype wire

// ==== rv_core.sv ====
////////////////////////////////////////////////////////////
// RV32I core top
// One instruction per clock through fetch to writeback
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module rv_core (
  input  wire logic               clk,
  input  wire logic               rst,
  output rv_isa_pkg::xlen_t       o_pc,
  input  wire rv_isa_pkg::insn_t  i_insn,
  output rv_core_pkg::dmem_req_t  o_dmem,
  input  wire rv_isa_pkg::xlen_t  i_dmem_rdata,
  output logic                    o_halt
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  ctrl_t    ctrl;
  reg_idx_t rs1_idx, rs2_idx;
  xlen_t    rs1_data, rs2_data;
  xlen_t    alu_result, target, rd_data;
  logic     branch_taken, rd_we;

  rv_fetch u_fetch (
    .clk            (clk),
    .rst            (rst),
    .i_branch_taken (branch_taken),
    .i_target       (target),
    .i_ecall        (ctrl.is_ecall),
    .o_pc           (o_pc),
    .o_halt         (o_halt)
  );

  rv_decode u_decode (
    .i_insn (i_insn),
    .o_ctrl (ctrl),
    .o_rs1  (rs1_idx),
    .o_rs2  (rs2_idx)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (rs1_idx),
    .i_rs2      (rs2_idx),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_rd       (ctrl.rd),
    .i_rd_data  (rd_data),
    .i_we       (rd_we)
  );

  rv_execute u_execute (
    .i_pc           (o_pc),
    .i_ctrl         (ctrl),
    .i_rs1_data     (rs1_data),
    .i_rs2_data     (rs2_data),
    .o_result       (alu_result),
    .o_branch_taken (branch_taken),
    .o_target       (target)
  );

  rv_mem_wb u_mem_wb (
    .rst          (rst),
    .i_pc         (o_pc),
    .i_ctrl       (ctrl),
    .i_result     (alu_result),
    .i_rs2_data   (rs2_data),
    .i_halt       (o_halt),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem       (o_dmem),
    .o_rd_data    (rd_data),
    .o_rd_we      (rd_we)
  );

endmodule

`default_nettype wire

// ==== tb_rv_core.sv ====
////////////////////////////////////////////////////////////
// Testbench for the RV32I core
// Runs small programs and checks stores against a reference
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "rv_macros.svh"

module tb_rv_core;
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  localparam int    CLK_PERIOD   = 20;
  localparam int    RESET_CYCLES = 8;
  localparam int    PROG_WORDS   = 256;
  localparam int    DMEM_WORDS   = 256;
  localparam xlen_t TRAP_ADDR    = 32'h0000_03F0;  // Stores here must never happen
  localparam xlen_t ECALL_WORD   = 32'h0000_0073;
  localparam xlen_t FENCE_WORD   = 32'h0FF0_000F;

  logic      clk;
  logic      rst;
  xlen_t     pc;
  insn_t     insn;
  dmem_req_t dmem_req;
  xlen_t     dmem_rdata;
  logic      halt;

  xlen_t     prog [PROG_WORDS];
  xlen_t     dmem [DMEM_WORDS];
  int        prog_len;
  xlen_t     slot;         // Next free result address
  dmem_req_t exp_stores [$];
  dmem_req_t exp_req;
  xlen_t     exp_pc;
  int        exp_count;
  int        err_count, test_count, pass_count;
  integer    seed;
  time       deadline;
  logic      ecall_prev;

  rv_core UUT (
    .clk          (clk),
    .rst          (rst),
    .o_pc         (pc),
    .i_insn       (insn),
    .o_dmem       (dmem_req),
    .i_dmem_rdata (dmem_rdata),
    .o_halt       (halt)
  );

  // Both memories answer in the same cycle
  assign insn       = insn_t'(prog[pc[9:2]]);
  assign dmem_rdata = rst ? '0 : dmem[dmem_req.addr[9:2]];

  function automatic xlen_t fill_word(input int idx);
    return xlen_t'(idx) * 32'h9E37_79B9 ^ 32'h0BAD_F00D;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= fill_word(i);
      end
    end else if (dmem_req.we) begin
      dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
    end
  end

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic xlen_t rnd_word();
    return $random(seed);
  endfunction

  task automatic append_insn(input xlen_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  task automatic alu_reg(input logic [2:0] f3, input logic [6:0] f7, input reg_idx_t rd,
                         input reg_idx_t rs1, input reg_idx_t rs2);
    append_insn({f7, rs2, rs1, f3, rd, OPC_OP});
  endtask

  task automatic alu_imm(input logic [2:0] f3, input reg_idx_t rd, input reg_idx_t rs1,
                         input logic [11:0] imm);
    append_insn({imm, rs1, f3, rd, OPC_OP_IMM});
  endtask

  task automatic load_upper(input reg_idx_t rd, input logic [19:0] imm);
    append_insn({imm, rd, OPC_LUI});
  endtask

  task automatic add_upper_pc(input reg_idx_t rd, input logic [19:0] imm);
    append_insn({imm, rd, OPC_AUIPC});
  endtask

  task automatic store_word(input reg_idx_t rs2, input xlen_t addr);
    append_insn({addr[11:5], rs2, 5'd0, 3'b010, addr[4:0], OPC_STORE});  // Base is x0
  endtask

  task automatic load_word(input reg_idx_t rd, input logic [11:0] addr);
    append_insn({addr, 5'd0, 3'b010, rd, OPC_LOAD});
  endtask

  task automatic branch_to(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2,
                           input logic [12:0] off);
    append_insn({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH});
  endtask

  task automatic jump_link(input reg_idx_t rd, input logic [20:0] off);
    append_insn({off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL});
  endtask

  task automatic jump_reg(input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
    append_insn({imm, rs1, 3'b000, rd, OPC_JALR});
  endtask

  // LUI/ADDI pair, upper part rounded for the signed low half
  task automatic load_const(input reg_idx_t rd, input xlen_t v);
    xlen_t hi;
    hi = (v + 32'h800) >> 12;
    load_upper(rd, hi[19:0]);
    alu_imm(3'd0, rd, rd, v[11:0]);
  endtask

  task automatic store_next(input reg_idx_t rs2);
    store_word(rs2, slot);
    slot += 4;
  endtask

  task automatic new_program();
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[i] = 32'h0000_0013;  // addi x0, x0, 0
    end
    prog_len = 0;
    slot     = 32'h0000_0200;
  endtask

  task automatic end_program();
    append_insn(ECALL_WORD);
    store_word(1, TRAP_ADDR);
    store_word(2, TRAP_ADDR);
  endtask

  function automatic xlen_t alu_model(input logic [2:0] f3, input logic alt, input xlen_t a,
                                      input xlen_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? xlen_t'($signed(a) >>> b[4:0]) : (a >> b[4:0]);
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_model(input logic [2:0] f3, input xlen_t a, input xlen_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Instruction set model, fills exp_stores and exp_pc
  function automatic void run_reference();
    xlen_t     regs [32];
    xlen_t     mem [DMEM_WORDS];
    xlen_t     cur, nxt, val, a, b, w, addr;
    xlen_t     imm_i, imm_s, imm_b, imm_j, imm_u;
    logic      wr;
    dmem_req_t req;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < DMEM_WORDS; i++) mem[i] = fill_word(i);
    exp_stores.delete();
    cur = `RV_RESET_PC;
    for (int step = 0; step < PROG_WORDS; step++) begin
      w     = prog[cur[9:2]];
      a     = regs[w[19:15]];
      b     = regs[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      imm_u = {w[31:12], 12'h000};
      nxt   = cur + 4;
      wr    = 1'b0;
      val   = '0;
      case (w[6:0])
        OPC_LUI: begin
          val = imm_u;
          wr  = 1'b1;
        end
        OPC_AUIPC: begin
          val = cur + imm_u;
          wr  = 1'b1;
        end
        OPC_JAL: begin
          val = cur + 4;
          wr  = 1'b1;
          nxt = cur + imm_j;
        end
        OPC_JALR: begin
          val = cur + 4;
          wr  = 1'b1;
          nxt = (a + imm_i) & 32'hFFFF_FFFE;
        end
        OPC_BRANCH: begin
          if (branch_model(w[14:12], a, b)) nxt = cur + imm_b;
        end
        OPC_LOAD: begin
          addr = a + imm_i;
          val  = mem[addr[9:2]];
          wr   = 1'b1;
        end
        OPC_STORE: begin
          req.addr  = a + imm_s;
          req.wdata = b;
          req.we    = 1'b1;
          mem[req.addr[9:2]] = b;
          exp_stores.push_back(req);
        end
        OPC_OP_IMM: begin
          val = alu_model(w[14:12], w[30] && (w[14:12] == 3'd5), a, imm_i);
          wr  = 1'b1;
        end
        OPC_OP: begin
          val = alu_model(w[14:12], w[30], a, b);
          wr  = 1'b1;
        end
        OPC_SYSTEM: begin
          exp_pc = cur;
          return;
        end
        default: ;
      endcase
      if (wr && w[11:7] != 5'd0) regs[w[11:7]] = val;
      cur = nxt;
    end
  endfunction

  task automatic check_store(input dmem_req_t got, input dmem_req_t exp);
    if (got.addr !== exp.addr) begin
      $display("FAIL t=%0t o_dmem.addr got %h expected %h", $time, got.addr, exp.addr);
      err_count++;
    end else if (got.wdata !== exp.wdata) begin
      $display("FAIL t=%0t o_dmem.wdata got %h expected %h", $time, got.wdata, exp.wdata);
      err_count++;
    end
  endtask

  task automatic check_pc(input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t o_pc got %h expected %h", $time, got, exp);
      err_count++;
    end
  endtask

  task automatic check_halt(input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL t=%0t o_halt got %b expected %b", $time, got, exp);
      err_count++;
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (rst) begin
      ecall_prev = 1'b0;
      check_halt(halt, 1'b0);
      if (dmem_req.we) begin
        $display("t=%0t store enable high while reset is held", $time);
        err_count++;
      end
    end else begin
      if (ecall_prev) check_halt(halt, 1'b1);  // One edge after ECALL
      ecall_prev = !halt && (insn == ECALL_WORD);
      if (dmem_req.we) begin
        if (exp_stores.size() == 0) begin
          $display("t=%0t unexpected store of %h to %h", $time, dmem_req.wdata, dmem_req.addr);
          err_count++;
        end else begin
          exp_req = exp_stores.pop_front();
          check_store(dmem_req, exp_req);
        end
      end
    end
  end

  always @(posedge clk) begin
    if ($time > deadline) begin
      $display("timeout at %0t, core never reached ECALL", $time);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic alu_program();
    xlen_t r;
    new_program();
    for (int round = 0; round < 2; round++) begin
      load_const(1, rnd_word());
      load_const(2, (round == 1) ? rnd_word() | 32'h8000_0000 : rnd_word());
      for (int f = 0; f < 8; f++) begin
        alu_reg(f, 7'h00, 5, 1, 2);
        store_next(5);
      end
      alu_reg(3'd0, 7'h20, 5, 1, 2);  // SUB
      store_next(5);
      alu_reg(3'd5, 7'h20, 5, 1, 2);  // SRA
      store_next(5);
      for (int f = 0; f < 8; f++) begin
        r = rnd_word();
        alu_imm(f, 5, 1, (f == 1 || f == 5) ? {7'h00, r[4:0]} : r[11:0]);
        store_next(5);
      end
      r = rnd_word();
      alu_imm(3'd5, 5, 1, {7'h20, r[4:0]});  // SRAI
      store_next(5);
    end
    end_program();
  endtask

  task automatic jump_program();
    xlen_t r;
    int    j;
    new_program();
    r = rnd_word();
    load_upper(6, r[19:0]);
    store_next(6);
    r = rnd_word();
    add_upper_pc(7, r[19:0]);
    store_next(7);
    jump_link(8, 21'd8);
    store_word(6, TRAP_ADDR);
    store_next(8);
    // Odd JALR target with a negative offset
    j = prog_len + 2;
    load_const(9, xlen_t'((j + 2) * 4 + 3));
    jump_reg(10, 9, 12'hFFE);
    store_word(7, TRAP_ADDR);
    store_next(10);
    end_program();
  endtask

  task automatic branch_program();
    logic [2:0] conds [6];
    conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    new_program();
    load_const(1, rnd_word() | 32'h8000_0000);
    load_const(2, rnd_word() & 32'h7FFF_FFFF);
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        branch_to(conds[c], (p == 1) ? 5'd2 : 5'd1, (p == 0) ? 5'd2 : 5'd1, 13'd8);
        store_next(1);  // Skipped when taken
        store_next(2);
      end
    end
    end_program();
  endtask

  task automatic load_store_program();
    xlen_t a;
    new_program();
    load_const(1, rnd_word());
    a = slot;
    store_next(1);
    load_word(2, a[11:0]);
    store_next(2);
    load_word(3, 12'h100);  // Untouched word, fill pattern
    store_next(3);
    end_program();
  endtask

  task automatic zero_reg_program();
    xlen_t r;
    new_program();
    store_next(0);  // Store at the reset PC waits for reset release
    load_const(1, rnd_word());
    alu_imm(3'd0, 0, 1, 12'h5A5);
    store_next(0);
    r = rnd_word();
    load_upper(0, r[19:0]);
    store_next(0);
    alu_reg(3'd0, 7'h00, 0, 1, 1);
    store_next(0);
    load_word(0, 12'h104);
    store_next(0);
    end_program();
  endtask

  task automatic halt_program();
    new_program();
    load_const(1, rnd_word());
    append_insn(FENCE_WORD);
    store_next(1);
    load_const(2, rnd_word());
    store_next(2);
    end_program();
  endtask

  task automatic run_test(input string name);
    int errs_before;
    errs_before = err_count;
    run_reference();
    exp_count = exp_stores.size();
    @(posedge clk);
    #2;
    rst      = 1'b1;
    deadline = $time + (prog_len * 3 + RESET_CYCLES) * CLK_PERIOD;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;
    while (!halt) @(negedge clk);
    check_pc(pc, exp_pc);
    repeat (4) begin  // Core must stay frozen
      @(negedge clk);
      check_pc(pc, exp_pc);
      check_halt(halt, 1'b1);
    end
    if (exp_stores.size() != 0) begin
      $display("%s: %0d expected stores never reached memory", name, exp_stores.size());
      err_count++;
    end
    test_count++;
    if (err_count == errs_before) begin
      pass_count++;
    end
    $display("test %s: %0d stores, %0d errors", name, exp_count, err_count - errs_before);
  endtask

  initial begin
    rst        = 1'b1;
    seed       = 77;
    err_count  = 0;
    test_count = 0;
    pass_count = 0;
    ecall_prev = 1'b0;
    deadline   = 64'hFFFF_FFFF_FFFF_FFFF;
    alu_program();
    run_test("alu");
    jump_program();
    run_test("jumps");
    branch_program();
    run_test("branches");
    load_store_program();
    run_test("load_store");
    zero_reg_program();
    run_test("x0");
    halt_program();
    run_test("halt");
    $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
             test_count, pass_count, test_count - pass_count, err_count);
    if (err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
rv_isa_pkg.sv
rv_core_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_mem_wb.sv
rv_core.sv
tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - .
    files:
      - rv_isa_pkg.sv
      - rv_core_pkg.sv
      - rv_fetch.sv
      - rv_decode.sv
      - rv_regfile.sv
      - rv_execute.sv
      - rv_mem_wb.sv
      - rv_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv_core.sv
